//--- hw/video_regs_pkg.sv
package video_regs_pkg;

    // Bus widths of the configuration and memory ports
    localparam int addr_width = 32;
    localparam int data_width = 32;

    // Register map, byte offsets
    localparam logic [addr_width-1:0] ctrl_offset    = 32'h0000_0000;
    localparam logic [addr_width-1:0] h1_offset      = 32'h0000_0028;
    localparam logic [addr_width-1:0] h2_offset      = 32'h0000_0030;
    localparam logic [addr_width-1:0] v1_offset      = 32'h0000_0038;
    localparam logic [addr_width-1:0] v2_offset      = 32'h0000_0040;
    localparam logic [addr_width-1:0] base_offset    = 32'h0000_0048;
    localparam logic [addr_width-1:0] lineinc_offset = 32'h0000_0050;
    localparam logic [addr_width-1:0] status_offset  = 32'h0000_0058;

    // Control register fields
    localparam int ctrl_en_bit = 3;
    localparam int pcnt_lsb    = 4;
    localparam int pcnt_width  = 6;

    // h1, h2, v1 and v2 each pack two timing fields
    localparam int timing_width  = 13;
    localparam int timing_hi_lsb = 13;                   // Upper field, lower one sits at bit 0

    // Status register
    localparam int underflow_bit = 0;

endpackage

//--- hw/video_pixel_pkg.sv
package video_pixel_pkg;

    // One displayed pixel, taken from memory word bits 23:0
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    localparam int fifo_depth      = 16;
    localparam int fifo_ptr_width  = 5;                  // Includes the wrap bit
    localparam int bytes_per_pixel = 4;                  // One 32-bit word per pixel
    localparam int count_width     = 13;                 // Raster h and v counters

endpackage

//--- hw/video_config_regs.sv
module video_config_regs (
    input  logic                                     clk,
    input  logic                                     reset_n,
    input  logic                                     cfg_cyc,
    input  logic                                     cfg_stb,
    input  logic                                     cfg_we,
    input  logic [video_regs_pkg::addr_width-1:0]    cfg_adr,
    input  logic [video_regs_pkg::data_width-1:0]    cfg_dat_w,
    output logic [video_regs_pkg::data_width-1:0]    cfg_dat_r,
    output logic                                     cfg_ack,
    input  logic                                     underflow,
    output logic                                     enable,
    output logic [video_regs_pkg::pcnt_width-1:0]    pcnt,
    output logic [video_regs_pkg::timing_width-1:0]  hsize,
    output logic [video_regs_pkg::timing_width-1:0]  hend,
    output logic [video_regs_pkg::timing_width-1:0]  hsync_start,
    output logic [video_regs_pkg::timing_width-1:0]  hsync_end,
    output logic [video_regs_pkg::timing_width-1:0]  vsize,
    output logic [video_regs_pkg::timing_width-1:0]  vend,
    output logic [video_regs_pkg::timing_width-1:0]  vsync_start,
    output logic [video_regs_pkg::timing_width-1:0]  vsync_end,
    output logic [video_regs_pkg::data_width-1:0]    base_address,
    output logic [video_regs_pkg::data_width-1:0]    lineinc
);

    localparam int tw = video_regs_pkg::timing_width;
    localparam int hi = video_regs_pkg::timing_hi_lsb;

    logic req_new;                                       // First cycle of a request
    logic wr_ctrl;
    logic underflow_sticky;

    assign req_new = cfg_cyc && cfg_stb && !cfg_ack;
    assign wr_ctrl = req_new && cfg_we && (cfg_adr == video_regs_pkg::ctrl_offset);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cfg_ack      <= 1'b0;
            enable       <= 1'b0;
            pcnt         <= '0;
            hsize        <= '0;
            hend         <= '0;
            hsync_start  <= '0;
            hsync_end    <= '0;
            vsize        <= '0;
            vend         <= '0;
            vsync_start  <= '0;
            vsync_end    <= '0;
            base_address <= '0;
            lineinc      <= '0;
        end else begin
            cfg_ack <= req_new;                          // Single-cycle ack
            if (req_new && cfg_we) begin
                case (cfg_adr)
                    video_regs_pkg::ctrl_offset: begin
                        enable <= cfg_dat_w[video_regs_pkg::ctrl_en_bit];
                        pcnt   <= cfg_dat_w[video_regs_pkg::pcnt_lsb +: video_regs_pkg::pcnt_width];
                    end
                    video_regs_pkg::h1_offset: begin
                        hsize <= cfg_dat_w[hi +: tw];
                        hend  <= cfg_dat_w[0 +: tw];
                    end
                    video_regs_pkg::h2_offset: begin
                        hsync_start <= cfg_dat_w[hi +: tw];
                        hsync_end   <= cfg_dat_w[0 +: tw];
                    end
                    video_regs_pkg::v1_offset: begin
                        vsize <= cfg_dat_w[hi +: tw];
                        vend  <= cfg_dat_w[0 +: tw];
                    end
                    video_regs_pkg::v2_offset: begin
                        vsync_start <= cfg_dat_w[hi +: tw];
                        vsync_end   <= cfg_dat_w[0 +: tw];
                    end
                    video_regs_pkg::base_offset:    base_address <= cfg_dat_w;
                    video_regs_pkg::lineinc_offset: lineinc      <= cfg_dat_w;
                    default: ;                           // Unmapped, write dropped
                endcase
            end
        end
    end

    // Sticky status, cleared by a write that turns the controller off
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            underflow_sticky <= 1'b0;
        end else if (wr_ctrl && !cfg_dat_w[video_regs_pkg::ctrl_en_bit]) begin
            underflow_sticky <= 1'b0;
        end else if (underflow && enable) begin      // Pulse registered before disable is dropped
            underflow_sticky <= 1'b1;
        end
    end

    always_comb begin
        cfg_dat_r = '0;
        case (cfg_adr)
            video_regs_pkg::ctrl_offset: begin
                cfg_dat_r[video_regs_pkg::ctrl_en_bit] = enable;
                cfg_dat_r[video_regs_pkg::pcnt_lsb +: video_regs_pkg::pcnt_width] = pcnt;
            end
            video_regs_pkg::h1_offset: cfg_dat_r[0 +: 2*tw] = {hsize, hend};
            video_regs_pkg::h2_offset: cfg_dat_r[0 +: 2*tw] = {hsync_start, hsync_end};
            video_regs_pkg::v1_offset: cfg_dat_r[0 +: 2*tw] = {vsize, vend};
            video_regs_pkg::v2_offset: cfg_dat_r[0 +: 2*tw] = {vsync_start, vsync_end};
            video_regs_pkg::base_offset:    cfg_dat_r = base_address;
            video_regs_pkg::lineinc_offset: cfg_dat_r = lineinc;
            video_regs_pkg::status_offset:  cfg_dat_r[video_regs_pkg::underflow_bit] = underflow_sticky;
            default: ;
        endcase
    end

    // Host holds its request through ack, the slave must still drop ack after one cycle
    ack_single_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        cfg_ack |=> !cfg_ack);

endmodule

//--- hw/pixel_fetch.sv
module pixel_fetch (
    input  logic                                     clk,
    input  logic                                     reset_n,
    input  logic                                     enable,
    input  logic [video_regs_pkg::timing_width-1:0]  hsize,
    input  logic [video_regs_pkg::timing_width-1:0]  vsize,
    input  logic [video_regs_pkg::data_width-1:0]    base_address,
    input  logic [video_regs_pkg::data_width-1:0]    lineinc,
    output logic                                     mem_cyc,
    output logic                                     mem_stb,
    output logic                                     mem_we,
    output logic [video_regs_pkg::addr_width-1:0]    mem_adr,
    input  logic [video_regs_pkg::data_width-1:0]    mem_dat_r,
    input  logic                                     mem_ack,
    input  logic                                     full,
    output logic                                     push,
    output video_pixel_pkg::pixel_t                  push_data
);

    logic [video_regs_pkg::timing_width-1:0] x_pos;
    logic [video_regs_pkg::timing_width-1:0] line;
    logic [video_regs_pkg::addr_width-1:0]   line_start;  // Address of pixel 0 on this line
    logic                                    done;
    logic                                    last_x;
    logic                                    last_line;

    assign done      = mem_cyc && mem_ack;
    assign last_x    = (x_pos == hsize - 1'b1);
    assign last_line = (line == vsize - 1'b1);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mem_cyc    <= 1'b0;
            x_pos      <= '0;
            line       <= '0;
            line_start <= '0;
            mem_adr    <= '0;
        end else if (!enable) begin
            mem_cyc    <= 1'b0;                          // Park at the top of the frame
            x_pos      <= '0;
            line       <= '0;
            line_start <= base_address;
            mem_adr    <= base_address;
        end else if (done) begin
            mem_cyc <= 1'b0;                             // Idle one cycle between reads
            if (!last_x) begin
                x_pos   <= x_pos + 1'b1;
                mem_adr <= mem_adr + video_pixel_pkg::bytes_per_pixel;
            end else begin
                x_pos <= '0;
                if (last_line) begin
                    line       <= '0;
                    line_start <= base_address;
                    mem_adr    <= base_address;
                end else begin
                    line       <= line + 1'b1;
                    line_start <= line_start + lineinc;
                    mem_adr    <= line_start + lineinc;
                end
            end
        end else if (!mem_cyc && !full) begin
            mem_cyc <= 1'b1;                             // FIFO has room, start a read
        end
    end

    assign mem_stb = mem_cyc;
    assign mem_we  = 1'b0;

    // Returned word goes straight into the FIFO
    assign push        = done;
    assign push_data.r = mem_dat_r[23:16];
    assign push_data.g = mem_dat_r[15:8];
    assign push_data.b = mem_dat_r[7:0];

    adr_stable: assert property (@(posedge clk) disable iff (!reset_n)
        (mem_stb && !mem_ack) |=> (!mem_stb || $stable(mem_adr)));

endmodule

//--- hw/pixel_fifo.sv
module pixel_fifo (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    flush,
    input  logic                    push,
    input  video_pixel_pkg::pixel_t push_data,
    input  logic                    pop,
    output video_pixel_pkg::pixel_t pop_data,
    output logic                    full,
    output logic                    empty
);

    localparam int pw = video_pixel_pkg::fifo_ptr_width;

    video_pixel_pkg::pixel_t storage [video_pixel_pkg::fifo_depth];

    logic [pw-1:0] wr_ptr;
    logic [pw-1:0] rd_ptr;

    always_ff @(posedge clk) begin
        if (push && !full) begin
            storage[wr_ptr[pw-2:0]] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Same index, wrap bits tell full from empty
    assign full  = (wr_ptr[pw-1] != rd_ptr[pw-1]) && (wr_ptr[pw-2:0] == rd_ptr[pw-2:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign pop_data = storage[rd_ptr[pw-2:0]];          // Show-ahead

    no_push_full: assert property (@(posedge clk) disable iff (!reset_n)
        push |-> !full);
    no_pop_empty: assert property (@(posedge clk) disable iff (!reset_n)
        pop |-> !empty);

endmodule

//--- hw/raster_timing.sv
module raster_timing (
    input  logic                                     clk,
    input  logic                                     reset_n,
    input  logic                                     enable,
    input  logic [video_regs_pkg::pcnt_width-1:0]    pcnt,
    input  logic [video_regs_pkg::timing_width-1:0]  hsize,
    input  logic [video_regs_pkg::timing_width-1:0]  hend,
    input  logic [video_regs_pkg::timing_width-1:0]  hsync_start,
    input  logic [video_regs_pkg::timing_width-1:0]  hsync_end,
    input  logic [video_regs_pkg::timing_width-1:0]  vsize,
    input  logic [video_regs_pkg::timing_width-1:0]  vend,
    input  logic [video_regs_pkg::timing_width-1:0]  vsync_start,
    input  logic [video_regs_pkg::timing_width-1:0]  vsync_end,
    input  logic                                     empty,
    input  video_pixel_pkg::pixel_t                  pop_data,
    output logic                                     pop,
    output logic                                     underflow,
    output logic                                     hsync,
    output logic                                     hblank,
    output logic                                     vsync,
    output logic                                     vblank,
    output logic [7:0]                               r,
    output logic [7:0]                               g,
    output logic [7:0]                               b
);

    logic [video_regs_pkg::pcnt_width-1:0]    div_cnt;
    logic [video_pixel_pkg::count_width-1:0]  h_cnt;
    logic [video_pixel_pkg::count_width-1:0]  v_cnt;
    logic                                     active;
    logic                                     first;    // First clock of a raster position
    video_pixel_pkg::pixel_t                  rgb_q;

    assign active = (h_cnt < hsize) && (v_cnt < vsize);
    assign first  = (div_cnt == '0);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            div_cnt <= '0;
            h_cnt   <= '0;
            v_cnt   <= '0;
        end else if (!enable) begin
            div_cnt <= '0;
            h_cnt   <= '0;
            v_cnt   <= '0;
        end else if (div_cnt == pcnt) begin
            div_cnt <= '0;
            if (h_cnt == hend) begin
                h_cnt <= '0;
                v_cnt <= (v_cnt == vend) ? '0 : v_cnt + 1'b1;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign pop = enable && active && first && !empty;

    // Outputs lag the counters by one clock
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            hsync     <= 1'b0;
            vsync     <= 1'b0;
            hblank    <= 1'b1;
            vblank    <= 1'b1;
            rgb_q     <= '0;
            underflow <= 1'b0;
        end else if (!enable) begin
            hsync     <= 1'b0;
            vsync     <= 1'b0;
            hblank    <= 1'b1;
            vblank    <= 1'b1;
            rgb_q     <= '0;
            underflow <= 1'b0;
        end else begin
            hsync     <= (h_cnt >= hsync_start) && (h_cnt < hsync_end);
            vsync     <= (v_cnt >= vsync_start) && (v_cnt < vsync_end);
            hblank    <= !(h_cnt < hsize);
            vblank    <= !(v_cnt < vsize);
            underflow <= active && first && empty;
            if (!active) begin
                rgb_q <= '0;
            end else if (first) begin
                rgb_q <= empty ? '0 : pop_data;          // Held for the whole position
            end
        end
    end

    assign r = rgb_q.r;
    assign g = rgb_q.g;
    assign b = rgb_q.b;

    h_in_range: assert property (@(posedge clk) disable iff (!reset_n)
        enable |-> (h_cnt <= hend));

endmodule

//--- hw/video_controller_top.sv
module video_controller_top (
    input  logic                                   clk,
    input  logic                                   reset_n,
    input  logic                                   cfg_cyc,
    input  logic                                   cfg_stb,
    input  logic                                   cfg_we,
    input  logic [video_regs_pkg::addr_width-1:0]  cfg_adr,
    input  logic [video_regs_pkg::data_width-1:0]  cfg_dat_w,
    output logic [video_regs_pkg::data_width-1:0]  cfg_dat_r,
    output logic                                   cfg_ack,
    output logic                                   mem_cyc,
    output logic                                   mem_stb,
    output logic                                   mem_we,
    output logic [video_regs_pkg::addr_width-1:0]  mem_adr,
    input  logic [video_regs_pkg::data_width-1:0]  mem_dat_r,
    input  logic                                   mem_ack,
    output logic                                   hsync,
    output logic                                   hblank,
    output logic                                   vsync,
    output logic                                   vblank,
    output logic [7:0]                             r,
    output logic [7:0]                             g,
    output logic [7:0]                             b
);

    logic                                    enable;
    logic                                    underflow;
    logic [video_regs_pkg::pcnt_width-1:0]   pcnt;
    logic [video_regs_pkg::timing_width-1:0] hsize, hend, hsync_start, hsync_end;
    logic [video_regs_pkg::timing_width-1:0] vsize, vend, vsync_start, vsync_end;
    logic [video_regs_pkg::data_width-1:0]   base_address, lineinc;
    logic                                    push, pop, full, empty;
    video_pixel_pkg::pixel_t                 push_data, pop_data;

    video_config_regs i_regs (
        .clk, .reset_n,
        .cfg_cyc, .cfg_stb, .cfg_we, .cfg_adr, .cfg_dat_w, .cfg_dat_r, .cfg_ack,
        .underflow, .enable, .pcnt,
        .hsize, .hend, .hsync_start, .hsync_end,
        .vsize, .vend, .vsync_start, .vsync_end,
        .base_address, .lineinc
    );

    pixel_fetch i_fetch (
        .clk, .reset_n,
        .enable, .hsize, .vsize, .base_address, .lineinc,
        .mem_cyc, .mem_stb, .mem_we, .mem_adr, .mem_dat_r, .mem_ack,
        .full, .push, .push_data
    );

    pixel_fifo i_fifo (
        .clk, .reset_n,
        .flush (!enable),                                // Drop stale pixels while off
        .push, .push_data, .pop, .pop_data, .full, .empty
    );

    raster_timing i_timing (
        .clk, .reset_n,
        .enable, .pcnt,
        .hsize, .hend, .hsync_start, .hsync_end,
        .vsize, .vend, .vsync_start, .vsync_end,
        .empty, .pop_data, .pop, .underflow,
        .hsync, .hblank, .vsync, .vblank, .r, .g, .b
    );

endmodule

//--- verification/frame_memory_model.sv
module frame_memory_model #(
    parameter logic [23:0] mix_pattern = 24'h5A_C3_96
) (
    input  logic        clk,
    input  logic        reset_n,
    input  int          wait_max,
    input  logic        mem_cyc,
    input  logic        mem_stb,
    input  logic        mem_we,
    input  logic [31:0] mem_adr,
    output logic [31:0] mem_dat_r,
    output logic        mem_ack
);

    integer seed;
    logic   busy;                                        // Request accepted, wait running
    int     count;

    initial begin
        seed = 32'h8911;
    end

    // Memory word is the address scrambled with a fixed pattern; writes are acked and dropped
    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mem_ack   <= 1'b0;
            mem_dat_r <= '0;
            busy      <= 1'b0;
            count     <= 0;
        end else begin
            mem_ack <= 1'b0;
            if (!mem_cyc || !mem_stb || mem_ack) begin
                busy <= 1'b0;                            // Master dropped the cycle or was acked
            end else if (!busy) begin
                busy  <= 1'b1;
                count <= $unsigned($random(seed)) % (wait_max + 1);
            end else if (count == 0) begin
                mem_ack   <= 1'b1;
                mem_dat_r <= mem_we ? 32'h0 : {8'h00, mem_adr[23:0] ^ mix_pattern};
            end else begin
                count <= count - 1;
            end
        end
    end

endmodule

//--- verification/video_controller_tb.sv
module video_controller_tb;

    localparam int          clk_period    = 40;
    localparam int          bus_timeout   = 50;
    localparam int          frame_timeout = 200000;
    localparam logic [23:0] mix_pattern   = 24'h5A_C3_96;

    typedef struct {
        string       name;
        int          pcnt;
        int          hsize, hend, hsync_start, hsync_end;
        int          vsize, vend, vsync_start, vsync_end;
        logic [31:0] base_address;
        logic [31:0] lineinc;
        int          wait_max;
        bit          starve;                             // Fetch cannot keep up in steady state
    } case_t;

    logic        clk;
    logic        reset_n;
    logic        cfg_cyc, cfg_stb, cfg_we;
    logic [31:0] cfg_adr, cfg_dat_w, cfg_dat_r;
    logic        cfg_ack;
    logic        mem_cyc, mem_stb, mem_we, mem_ack;
    logic [31:0] mem_adr, mem_dat_r;
    logic        hsync, hblank, vsync, vblank;
    logic [7:0]  r, g, b;
    int          wait_max;
    int          errors;
    int          checks;
    case_t       cases [4];

    video_controller_top i_dut (
        .clk, .reset_n,
        .cfg_cyc, .cfg_stb, .cfg_we, .cfg_adr, .cfg_dat_w, .cfg_dat_r, .cfg_ack,
        .mem_cyc, .mem_stb, .mem_we, .mem_adr, .mem_dat_r, .mem_ack,
        .hsync, .hblank, .vsync, .vblank, .r, .g, .b
    );

    frame_memory_model #(.mix_pattern(mix_pattern)) i_mem (
        .clk, .reset_n, .wait_max,
        .mem_cyc, .mem_stb, .mem_we, .mem_adr, .mem_dat_r, .mem_ack
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Fetch order is line by line, so fetch index f maps to one address
    function automatic logic [23:0] expected_rgb(case_t c, int q);
        int          n;
        int          f;
        logic [31:0] addr;
        n = c.hsize * c.vsize;
        f = (q + n - 1) % n;                             // Startup underflow leaves stream one behind
        addr = c.base_address + (f / c.hsize) * c.lineinc + (f % c.hsize) * 4;
        return addr[23:0] ^ mix_pattern;
    endfunction

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic give_up(string what);
        errors++;
        $display("Timeout: %s", what);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("=== FAIL ===");
        $finish;
    endtask

    task automatic bus_access(logic we, logic [31:0] adr, logic [31:0] wdata,
                              output logic [31:0] rdata);
        int n;
        @(posedge clk);
        cfg_cyc   <= 1'b1;
        cfg_stb   <= 1'b1;
        cfg_we    <= we;
        cfg_adr   <= adr;
        cfg_dat_w <= wdata;
        n = 0;
        @(negedge clk);
        while (!cfg_ack && n < bus_timeout) begin
            @(negedge clk);
            n++;
        end
        if (!cfg_ack) give_up("no ack on the configuration bus");
        rdata = cfg_dat_r;
        @(posedge clk);
        cfg_cyc <= 1'b0;
        cfg_stb <= 1'b0;
        cfg_we  <= 1'b0;
    endtask

    task automatic write_reg(logic [31:0] adr, logic [31:0] data);
        logic [31:0] unused;
        bus_access(1'b1, adr, data, unused);
    endtask

    task automatic read_reg(logic [31:0] adr, output logic [31:0] data);
        bus_access(1'b0, adr, 32'h0, data);
    endtask

    task automatic write_and_verify(string name, logic [31:0] adr, logic [31:0] data);
        logic [31:0] rd;
        write_reg(adr, data);
        read_reg(adr, rd);
        check_value({name, " readback"}, data, rd);
    endtask

    task automatic wait_vblank(logic level);
        int n;
        n = 0;
        @(negedge clk);
        while (vblank !== level && n < frame_timeout) begin
            @(negedge clk);
            n++;
        end
        if (vblank !== level) give_up("vblank never reached the expected level");
    endtask

    task automatic run_case(case_t c);
        logic [31:0] rd;
        logic [23:0] held;
        logic [23:0] rgb;
        int          ppc;
        int          n_vblank, n_vsync, hb_low, hs_high, pos_clk, vline, clocks, zeros;
        bit          prev_hblank, prev_vblank, in_line, done;
        ppc = c.pcnt + 1;
        @(posedge clk);
        wait_max <= c.wait_max;
        write_reg(video_regs_pkg::ctrl_offset, 32'h0);
        repeat (2) @(negedge clk);
        repeat (8) begin
            @(negedge clk);
            check_value({c.name, " disabled mem_cyc"}, 0, mem_cyc);
            check_value({c.name, " disabled blanks"}, 2'b11, {hblank, vblank});
            check_value({c.name, " disabled rgb"}, 0, {r, g, b});
        end
        read_reg(video_regs_pkg::status_offset, rd);
        check_value({c.name, " status after disable"}, 0, rd);
        write_and_verify({c.name, " h1"}, video_regs_pkg::h1_offset, (c.hsize << 13) | c.hend);
        write_and_verify({c.name, " h2"}, video_regs_pkg::h2_offset,
                         (c.hsync_start << 13) | c.hsync_end);
        write_and_verify({c.name, " v1"}, video_regs_pkg::v1_offset, (c.vsize << 13) | c.vend);
        write_and_verify({c.name, " v2"}, video_regs_pkg::v2_offset,
                         (c.vsync_start << 13) | c.vsync_end);
        write_and_verify({c.name, " base"}, video_regs_pkg::base_offset, c.base_address);
        write_and_verify({c.name, " lineinc"}, video_regs_pkg::lineinc_offset, c.lineinc);
        write_reg(32'h04, 32'hFFFF_FFFF);
        read_reg(32'h04, rd);
        check_value({c.name, " unmapped 0x04"}, 0, rd);
        read_reg(32'h60, rd);
        check_value({c.name, " unmapped 0x60"}, 0, rd);
        write_and_verify({c.name, " ctrl"}, video_regs_pkg::ctrl_offset,
                         32'h8 | (c.pcnt << 4));

        wait_vblank(1'b0);                               // Frame 1 starts
        wait_vblank(1'b1);
        wait_vblank(1'b0);                               // Frame 2 starts on this clock
        prev_hblank = 1'b1;
        prev_vblank = 1'b0;
        in_line     = 1'b0;
        done        = 1'b0;
        vline       = -1;
        clocks      = 0;
        zeros       = 0;
        n_vblank    = 0;
        n_vsync     = 0;
        while (!done) begin
            rgb = {r, g, b};
            if (prev_hblank && !hblank) begin            // Line start
                if (in_line) begin
                    check_value({c.name, " hblank low clocks"}, c.hsize * ppc, hb_low);
                    check_value({c.name, " hsync clocks"},
                                (c.hsync_end - c.hsync_start) * ppc, hs_high);
                end
                if (prev_vblank && !vblank) begin
                    done = 1'b1;                         // Frame 3 begins
                end else begin
                    in_line = 1'b1;
                    hb_low  = 0;
                    hs_high = 0;
                    pos_clk = 0;
                    if (!vblank) begin
                        n_vblank++;
                        vline++;
                    end
                    if (vsync) n_vsync++;
                end
            end
            if (!done) begin
                // Single classic reads, stb follows cyc and the bus never writes
                check_value({c.name, " mem strobe"}, {mem_cyc, 1'b0}, {mem_stb, mem_we});
                if (!hblank) hb_low++;
                if (hsync) hs_high++;
                if (!hblank && !vblank) begin
                    if (pos_clk % ppc == 0) begin
                        held = rgb;
                        if (rgb == 0) zeros++;
                        if (!c.starve) begin
                            check_value({c.name, " pixel"},
                                        expected_rgb(c, vline * c.hsize + pos_clk / ppc), rgb);
                        end
                    end else begin
                        check_value({c.name, " pixel hold"}, held, rgb);
                    end
                    pos_clk++;
                end
                prev_hblank = hblank;
                prev_vblank = vblank;
                clocks++;
                if (clocks > frame_timeout) give_up("second frame never ended");
                @(negedge clk);
            end
        end
        check_value({c.name, " vblank low lines"}, c.vsize, n_vblank);
        check_value({c.name, " vsync lines"}, c.vsync_end - c.vsync_start, n_vsync);
        if (c.starve) check_value({c.name, " starved positions"}, 1, zeros > 0);
        // The first position after enable always finds the FIFO flushed
        read_reg(video_regs_pkg::status_offset, rd);
        check_value({c.name, " status underflow"}, 1, rd[video_regs_pkg::underflow_bit]);
    endtask

    initial begin
        logic [31:0] rd;
        errors    = 0;
        checks    = 0;
        reset_n   = 1'b0;
        cfg_cyc   = 1'b0;
        cfg_stb   = 1'b0;
        cfg_we    = 1'b0;
        cfg_adr   = '0;
        cfg_dat_w = '0;
        wait_max  = 0;
        cases[0] = '{"slow_p3", 3, 8, 11, 9, 11, 4, 6, 5, 6, 32'h0001_0000, 32'h100, 0, 1'b0};
        cases[1] = '{"slow_p7", 7, 5, 7, 5, 6, 3, 4, 3, 4, 32'h0020_0400, 32'h40, 2, 1'b0};
        cases[2] = '{"mid_p1", 1, 16, 23, 17, 20, 6, 8, 7, 8, 32'h0003_0000, 32'h80, 1, 1'b1};
        cases[3] = '{"fast_p0", 0, 64, 79, 66, 70, 4, 5, 4, 5, 32'h0040_0000, 32'h200, 3, 1'b1};
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;
        foreach (cases[i]) begin
            run_case(cases[i]);
        end
        write_reg(video_regs_pkg::ctrl_offset, 32'h0);
        read_reg(video_regs_pkg::status_offset, rd);
        check_value("final status after disable", 0, rd);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- all.f
hw/video_regs_pkg.sv
hw/video_pixel_pkg.sv
hw/video_config_regs.sv
hw/pixel_fetch.sv
hw/pixel_fifo.sv
hw/raster_timing.sv
hw/video_controller_top.sv
verification/frame_memory_model.sv
verification/video_controller_tb.sv

//--- Bender.yml
package:
  name: video_controller

sources:
  - hw/video_regs_pkg.sv
  - hw/video_pixel_pkg.sv
  - hw/video_config_regs.sv
  - hw/pixel_fetch.sv
  - hw/pixel_fifo.sv
  - hw/raster_timing.sv
  - hw/video_controller_top.sv
  - target: simulation
    files:
      - verification/frame_memory_model.sv
      - verification/video_controller_tb.sv
